/* files.f */
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/mem_bus_arbiter.sv
logic/rv_core_top.sv
tests/rv_core_tb.sv

/* logic/mem_bus_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Memory port arbiter
// Fixed priority, execute over fetch, grant held until acknowledge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_bus_arbiter import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  mem_req_t fetch_req,
    output logic     fetch_ack,
    input  logic     exec_valid,
    input  mem_req_t exec_req,
    output logic     exec_ack,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_ack
);

    // Owner of the port, high for execute
    logic grant_exec;
    // Set from the first request cycle up to the ack
    logic lock;
    logic sel_exec;

    // Idle port goes to execute first
    assign sel_exec = lock ? grant_exec : exec_valid;

    assign mem_req_valid = sel_exec ? exec_valid : fetch_valid;
    assign mem_req       = sel_exec ? exec_req : fetch_req;

    // Ack steered to the owner only
    assign fetch_ack = mem_ack && lock && !grant_exec;
    assign exec_ack  = mem_ack && lock && grant_exec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock       <= 1'b0;
            grant_exec <= 1'b0;
        end else if (!lock && mem_req_valid) begin
            lock       <= 1'b1;
            grant_exec <= sel_exec;
        end else if (lock && mem_ack) begin
            lock <= 1'b0;
        end
    end

    // Every ack lands on exactly one client, never both
    a_one_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_ack |-> (fetch_ack != exec_ack)
    );

endmodule

`default_nettype wire

/* logic/rv_core_config.svh */
////////////////////////////////////////////////////////////////////////////
// RV32I core configuration
// Reset vector, register count and trace default
////////////////////////////////////////////////////////////////////////////

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Address of the first instruction fetch after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// Retire trace printing on by default
`define RV_TRACE_EN 1

`endif

/* logic/rv_core_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// RV32I core types
// Opcodes, redirect command, memory request and stage payloads
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rv_core_pkg;

    // Supported major opcodes, everything else retires as a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    // Redirect from execute back towards fetch
    typedef enum logic {
        CMD_NONE   = 1'b0,
        CMD_BRANCH = 1'b1
    } redirect_cmd_e;

    // One word access on the shared memory port
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

    // Fetch to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } f2d_t;

    // Decode to execute, operands already read
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } d2e_t;

    // Retire trace, one per completed instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] rd_value;
    } retire_t;

endpackage

`default_nettype wire

/* logic/rv_core_top.sv */
////////////////////////////////////////////////////////////////////////////
// RV32I core top level
// Fetch, decode, execute, register file and memory arbiter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata,
    output logic        retire_valid,
    output retire_t     retire,
    output logic        dbg_busy
);

    // Fetch to decode
    logic          f2d_valid;
    f2d_t          f2d;
    logic          d2f_ready;
    redirect_cmd_e d2f_cmd;
    logic [31:0]   d2f_target;

    // Decode to execute, with redirect and hazard feedback
    logic          d2e_valid;
    d2e_t          d2e;
    logic          e2d_ready;
    redirect_cmd_e e2d_cmd;
    logic [31:0]   e2d_target;
    logic          ex_busy;
    logic [4:0]    ex_rd;
    logic          ex_rd_we;

    // Register file ports
    logic [4:0]    rs1_addr;
    logic [4:0]    rs2_addr;
    logic [31:0]   rs1_value;
    logic [31:0]   rs2_value;
    logic          rd_we;
    logic [4:0]    rd_addr;
    logic [31:0]   rd_value;

    // Arbiter clients
    logic          fetch_req_valid;
    mem_req_t      fetch_req;
    logic          fetch_ack;
    logic          exec_req_valid;
    mem_req_t      exec_req;
    logic          exec_ack;

    // Same-named nets connect implicitly, the rest are listed
    rv_fetch fetch_i (
        .*,
        .req_valid (fetch_req_valid),
        .req       (fetch_req),
        .ack       (fetch_ack),
        .rdata     (mem_rdata)
    );

    rv_decode decode_i (
        .*,
        .busy (dbg_busy)
    );

    rv_regfile regfile_i (.*);

    rv_execute execute_i (
        .*,
        .busy          (ex_busy),
        .rd            (ex_rd),
        .rd_we_pending (ex_rd_we),
        .req_valid     (exec_req_valid),
        .req           (exec_req),
        .ack           (exec_ack),
        .rdata         (mem_rdata)
    );

    // Read data goes to both clients directly
    mem_bus_arbiter arbiter_i (
        .*,
        .fetch_valid (fetch_req_valid),
        .exec_valid  (exec_req_valid)
    );

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
////////////////////////////////////////////////////////////////////////////
// Decode stage
// Register reads, read-after-write stall against execute, and the
// redirect path from execute back to fetch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          f2d_valid,
    input  f2d_t          f2d,
    output logic          d2f_ready,
    output redirect_cmd_e d2f_cmd,
    output logic [31:0]   d2f_target,
    output logic [4:0]    rs1_addr,
    output logic [4:0]    rs2_addr,
    input  logic [31:0]   rs1_value,
    input  logic [31:0]   rs2_value,
    output logic          d2e_valid,
    output d2e_t          d2e,
    input  logic          e2d_ready,
    input  redirect_cmd_e e2d_cmd,
    input  logic [31:0]   e2d_target,
    input  logic          ex_busy,
    input  logic [4:0]    ex_rd,
    input  logic          ex_rd_we,
    output logic          busy
);

    opcode_e opcode;
    logic    uses_rs1;
    logic    uses_rs2;
    logic    raw_match;
    logic    redirect;
    logic    issue;

    ////////////////////////////////////////////////////////////////////////////
    // Source operands and hazard check
    ////////////////////////////////////////////////////////////////////////////

    assign opcode   = opcode_e'(f2d.instr[6:0]);
    assign rs1_addr = f2d.instr[19:15];
    assign rs2_addr = f2d.instr[24:20];

    // LUI and JAL read no register, only R, branch and store read rs2
    assign uses_rs1 = (opcode != OP_LUI) && (opcode != OP_JAL);
    assign uses_rs2 = (opcode == OP_REG) || (opcode == OP_BRANCH) || (opcode == OP_STORE);

    // Execute writes rd at its completion edge, no bypass
    assign raw_match = ex_busy && ex_rd_we && (ex_rd != 5'd0) &&
                       ((uses_rs1 && (ex_rd == rs1_addr)) ||
                        (uses_rs2 && (ex_rd == rs2_addr)));

    assign redirect = (e2d_cmd == CMD_BRANCH);

    // Slot free or emptying, nothing to wait for, no flush
    assign d2f_ready = (!d2e_valid || e2d_ready) && !raw_match && !redirect;
    assign issue     = f2d_valid && d2f_ready;

    // Redirect goes straight through to fetch
    assign d2f_cmd    = e2d_cmd;
    assign d2f_target = e2d_target;

    assign busy = f2d_valid || d2e_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Output register towards execute
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d2e_valid <= 1'b0;
        end else if (redirect) begin
            d2e_valid <= 1'b0;
        end else if (issue) begin
            d2e_valid <= 1'b1;
        end else if (e2d_ready) begin
            d2e_valid <= 1'b0;
        end
    end

    // Operands sampled on the cycle of issue
    always_ff @(posedge clk) begin
        if (issue) begin
            d2e.pc        <= f2d.pc;
            d2e.instr     <= f2d.instr;
            d2e.rs1_value <= rs1_value;
            d2e.rs2_value <= rs2_value;
        end
    end

    // Nothing from the wrong path reaches execute or waits in fetch
    a_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        (e2d_cmd == CMD_BRANCH) |=> (!d2e_valid && !f2d_valid)
    );

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage
// ALU, branch resolution, word loads and stores, write-back and retire
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          d2e_valid,
    input  d2e_t          d2e,
    output logic          e2d_ready,
    output redirect_cmd_e e2d_cmd,
    output logic [31:0]   e2d_target,
    output logic          busy,
    output logic [4:0]    rd,
    output logic          rd_we_pending,
    output logic          rd_we,
    output logic [4:0]    rd_addr,
    output logic [31:0]   rd_value,
    output logic          req_valid,
    output mem_req_t      req,
    input  logic          ack,
    input  logic [31:0]   rdata,
    output logic          retire_valid,
    output retire_t       retire
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] result;
    logic [31:0] target;
    logic [31:0] mem_addr;
    logic        wr_en;
    logic        is_mem;
    logic        taken;
    logic        start;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields and immediates
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = opcode_e'(d2e.instr[6:0]);
    assign funct3 = d2e.instr[14:12];
    assign rd     = d2e.instr[11:7];

    assign imm_i = {{20{d2e.instr[31]}}, d2e.instr[31:20]};
    assign imm_s = {{20{d2e.instr[31]}}, d2e.instr[31:25], d2e.instr[11:7]};
    assign imm_b = {{19{d2e.instr[31]}}, d2e.instr[31], d2e.instr[7],
                    d2e.instr[30:25], d2e.instr[11:8], 1'b0};
    assign imm_j = {{11{d2e.instr[31]}}, d2e.instr[31], d2e.instr[19:12],
                    d2e.instr[20], d2e.instr[30:21], 1'b0};
    assign imm_u = {d2e.instr[31:12], 12'd0};

    // Operation select, unsupported encodings fall through as no-ops
    always_comb begin
        result   = 32'd0;
        target   = d2e.pc + imm_b;
        mem_addr = d2e.rs1_value + imm_i;
        wr_en    = 1'b0;
        is_mem   = 1'b0;
        taken    = 1'b0;
        case (opcode)
            OP_LUI: begin
                result = imm_u;
                wr_en  = 1'b1;
            end
            OP_IMM: begin
                // ADDI only
                result = d2e.rs1_value + imm_i;
                wr_en  = (funct3 == 3'b000);
            end
            OP_REG: begin
                wr_en = 1'b1;
                case (funct3)
                    3'b000: result = d2e.instr[30] ? d2e.rs1_value - d2e.rs2_value
                                                   : d2e.rs1_value + d2e.rs2_value;
                    3'b100: result = d2e.rs1_value ^ d2e.rs2_value;
                    3'b110: result = d2e.rs1_value | d2e.rs2_value;
                    3'b111: result = d2e.rs1_value & d2e.rs2_value;
                    default: wr_en = 1'b0;
                endcase
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) begin
                    taken = (d2e.rs1_value == d2e.rs2_value);
                end else if (funct3 == 3'b001) begin
                    taken = (d2e.rs1_value != d2e.rs2_value);
                end
            end
            OP_JAL: begin
                // Link value, target from the J immediate
                result = d2e.pc + 32'd4;
                target = d2e.pc + imm_j;
                wr_en  = 1'b1;
                taken  = 1'b1;
            end
            OP_LOAD: begin
                is_mem = (funct3 == 3'b010);
                wr_en  = (funct3 == 3'b010);
            end
            OP_STORE: begin
                is_mem   = (funct3 == 3'b010);
                mem_addr = d2e.rs1_value + imm_s;
            end
            default: begin
            end
        endcase
        if (rd == 5'd0) begin
            wr_en = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing and completion
    ////////////////////////////////////////////////////////////////////////////

    // New instruction seen, not yet completing or waiting on memory
    assign start = d2e_valid && !retire_valid && !req_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            req_valid    <= 1'b0;
            e2d_cmd      <= CMD_NONE;
        end else begin
            retire_valid <= 1'b0;
            e2d_cmd      <= CMD_NONE;
            if (start && is_mem) begin
                req_valid <= 1'b1;
            end else if (start) begin
                retire_valid <= 1'b1;
                e2d_cmd      <= taken ? CMD_BRANCH : CMD_NONE;
            end else if (req_valid && ack) begin
                req_valid    <= 1'b0;
                retire_valid <= 1'b1;
            end
        end
    end

    // Payload, loaded at start and patched with load data on ack
    always_ff @(posedge clk) begin
        if (start) begin
            retire.pc       <= d2e.pc;
            retire.rd       <= rd;
            retire.rd_we    <= wr_en;
            retire.rd_value <= result;
            e2d_target      <= target;
            req.addr        <= mem_addr;
            req.wdata       <= d2e.rs2_value;
            req.we          <= (opcode == OP_STORE);
        end else if (req_valid && ack && !req.we) begin
            retire.rd_value <= rdata;
        end
    end

    // Write-back rides on the retire record
    assign rd_we         = retire_valid && retire.rd_we;
    assign rd_addr       = retire.rd;
    assign rd_value      = retire.rd_value;
    assign rd_we_pending = wr_en;
    assign busy          = d2e_valid;
    assign e2d_ready     = d2e_valid && retire_valid;

    // Decode keeps the instruction until it retires
    a_ready_retire: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid == e2d_ready
    );

endmodule

`default_nettype wire

/* logic/rv_fetch.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch stage
// One instruction read at a time, fetched word registered towards decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_fetch import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    output logic          f2d_valid,
    output f2d_t          f2d,
    input  logic          d2f_ready,
    input  redirect_cmd_e d2f_cmd,
    input  logic [31:0]   d2f_target,
    output logic          req_valid,
    output mem_req_t      req,
    input  logic          ack,
    input  logic [31:0]   rdata
);

    logic [31:0] pc;
    // Set when a redirect lands on an outstanding read
    logic        discard;
    logic        redirect;

    assign redirect = (d2f_cmd == CMD_BRANCH);

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RV_RESET_PC;
            f2d_valid <= 1'b0;
            req_valid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            // Redirect wins over a handshake with decode
            if (redirect) begin
                pc        <= d2f_target;
                f2d_valid <= 1'b0;
                if (req_valid && !ack) begin
                    discard <= 1'b1;
                end
            end else if (f2d_valid && d2f_ready) begin
                pc        <= pc + 32'd4;
                f2d_valid <= 1'b0;
            end

            if (req_valid && ack) begin
                req_valid <= 1'b0;
                discard   <= 1'b0;
                // Stale word from the old path is dropped here
                if (!discard && !redirect) begin
                    f2d_valid <= 1'b1;
                end
            end else if (!req_valid && !f2d_valid && !discard && !redirect) begin
                req_valid <= 1'b1;
            end
        end
    end

    // Request and fetched word, payload only
    always_ff @(posedge clk) begin
        if (!req_valid && !f2d_valid && !discard && !redirect) begin
            req.addr  <= pc;
            req.wdata <= 32'd0;
            req.we    <= 1'b0;
        end
        if (req_valid && ack) begin
            f2d.pc    <= req.addr;
            f2d.instr <= rdata;
        end
    end

    // Request held until its acknowledge
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_valid && !ack) |=> $stable(req)
    );

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
////////////////////////////////////////////////////////////////////////////
// Register file
// Two combinational read ports, one write port, x0 fixed at zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    input  logic        rd_we,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_value
);

    logic [31:0] regs [`RV_NUM_REGS];

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (rd_we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_value;
        end
    end

    assign rs1_value = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

# Pass only when the testbench printed its pass line
grep -q "^TEST RESULT: PASS$" sim.log

/* tests/rv_core_tb.sv */
////////////////////////////////////////////////////////////////////////////
// RV32I core testbench
// Random program, random-latency memory, ISA model and retire scoreboard
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb import rv_core_pkg::*;;

    localparam int PROG_LEN = 200;
    localparam int MAX_EXP  = 1000;
    localparam int TIMEOUT  = 2000;
    localparam int T_ORDER  = 0;
    localparam int T_BRANCH = 1;
    localparam int T_MEM    = 2;
    localparam int T_RAW    = 3;
    localparam int T_RESET  = 4;
    localparam int T_DONE   = 5;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        retire_valid;
    retire_t     retire;
    logic        dbg_busy;

    // Word memory seen by the DUT, and the model's own copy
    logic [31:0] mem [0:1023];
    logic [31:0] model_mem [0:1023];

    // Expected retire stream, 1 marks a load, 2 an ADDI chain member
    logic [31:0] exp_pc [MAX_EXP];
    logic [4:0]  exp_rd [MAX_EXP];
    logic        exp_we [MAX_EXP];
    logic [31:0] exp_val [MAX_EXP];
    int          exp_kind [MAX_EXP];
    int          exp_n;
    logic [31:0] st_addr [MAX_EXP];
    logic [31:0] st_data [MAX_EXP];
    int          st_n;
    int          st_idx;
    bit          is_chain [PROG_LEN + 1];

    string       test_name [6] = '{"retire_order", "branch_redirect", "memory_writes",
                                   "raw_hazard", "reset_idle", "completion"};
    int          err_cnt [6];
    int          chk_cnt [6];

    // Memory responder state
    logic        mem_busy;
    mem_req_t    cur_req;
    logic [1:0]  lat;

    rv_core_top dut_i (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare and report helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input int t, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt[t]++;
        assert (exp === act) else begin
            $display("Mismatch %s: expected %h, actual %h", test_name[t], exp, act);
            err_cnt[t]++;
        end
    endtask

    task automatic check_true(input int t, input bit cond, input string what);
        chk_cnt[t]++;
        assert (cond) else begin
            $display("Error %s: %s", test_name[t], what);
            err_cnt[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("%s: %0d checks, %0d errors", test_name[t], chk_cnt[t], err_cnt[t]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program generation and ISA model
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_program();
        int          sel;
        int          skip;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] dofs;
        logic [31:0] w;
        for (int i = 0; i < 1024; i++) begin
            // Fill pattern covers every address bit
            mem[i] = 32'(i) * 32'h9e37_79b9;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rd   = 5'($urandom_range(0, 7));
            rs1  = 5'($urandom_range(0, 7));
            rs2  = 5'($urandom_range(0, 7));
            skip = $urandom_range(1, 3);
            if (i + skip + 1 > PROG_LEN) begin
                skip = PROG_LEN - i - 1;
            end
            dofs = 12'h400 + 12'($urandom_range(0, 63) * 4);
            // Dependent ADDI chain on x6 at fixed points
            sel = ((i % 40) >= 20 && (i % 40) < 24) ? 100 : $urandom_range(0, 9);
            is_chain[i] = (sel == 100);
            case (sel)
                100: w = enc_i(12'($urandom_range(0, 255)), 5'd6, 3'b000, 5'd6, 7'h13);
                0: w = {20'($urandom), rd, 7'h37};
                1, 2, 9: w = enc_i(12'($urandom), rs1, 3'b000, rd, 7'h13);
                3: begin
                    case ($urandom_range(0, 4))
                        0: w = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                        1: w = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                        2: w = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                        3: w = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                        default: w = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                    endcase
                end
                4: w = enc_b(13'((skip + 1) * 4), rs2, rs1, 3'b000);
                5: w = enc_b(13'((skip + 1) * 4), rs2, rs1, 3'b001);
                6: w = enc_j(21'((skip + 1) * 4), rd);
                7: w = enc_i(dofs, 5'd0, 3'b010, rd, 7'h03);
                default: w = enc_s(dofs, rs2);
            endcase
            mem[i] = w;
        end
        // Final self-loop
        mem[PROG_LEN] = enc_j(21'd0, 5'd0);
        is_chain[PROG_LEN] = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = mem[i];
        end
    endtask

    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic        we;
        int          kind;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'd0;
        end
        pc    = `RV_RESET_PC;
        exp_n = 0;
        st_n  = 0;
        while (pc != `RV_RESET_PC + PROG_LEN * 4 && exp_n < MAX_EXP) begin
            ins  = model_mem[10'((pc - `RV_RESET_PC) >> 2)];
            a    = r[ins[19:15]];
            b    = r[ins[24:20]];
            nxt  = pc + 4;
            val  = 32'd0;
            we   = 1'b0;
            kind = is_chain[(pc - `RV_RESET_PC) >> 2] ? 2 : 0;
            case (ins[6:0])
                7'h37: begin
                    val = {ins[31:12], 12'd0};
                    we  = 1'b1;
                end
                7'h13: begin
                    val = a + {{20{ins[31]}}, ins[31:20]};
                    we  = 1'b1;
                end
                7'h33: begin
                    we = 1'b1;
                    case (ins[14:12])
                        3'b000: val = ins[30] ? a - b : a + b;
                        3'b100: val = a ^ b;
                        3'b110: val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'h63: begin
                    if ((ins[12] == 1'b0) == (a == b)) begin
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    val = pc + 4;
                    we  = 1'b1;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h03: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    val  = model_mem[addr[11:2]];
                    we   = 1'b1;
                    kind = 1;
                end
                default: begin
                    // Store
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    model_mem[addr[11:2]] = b;
                    st_addr[st_n] = addr;
                    st_data[st_n] = b;
                    st_n++;
                end
            endcase
            if (ins[11:7] == 5'd0) begin
                we = 1'b0;
            end
            if (we) begin
                r[ins[11:7]] = val;
            end
            exp_pc[exp_n]   = pc;
            exp_rd[exp_n]   = ins[11:7];
            exp_we[exp_n]   = we;
            exp_val[exp_n]  = val;
            exp_kind[exp_n] = kind;
            exp_n++;
            pc = nxt;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory responder, ack 1 to 4 cycles after the request is seen
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (!rst_n) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (lat == 2'd0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[cur_req.addr[11:2]];
                if (cur_req.we) begin
                    mem[cur_req.addr[11:2]] = cur_req.wdata;
                end
                mem_busy <= 1'b0;
            end else begin
                lat <= lat - 2'd1;
            end
        end else if (mem_req_valid && !mem_ack) begin
            mem_busy <= 1'b1;
            cur_req  <= mem_req;
            lat      <= 2'($urandom_range(0, 3));
            if (mem_req.we) begin
                check_true(T_MEM, st_idx < st_n, "store issued beyond the model's stores");
                if (st_idx < st_n) begin
                    check_value(T_MEM, st_addr[st_idx], mem_req.addr);
                    check_value(T_MEM, st_data[st_idx], mem_req.wdata);
                end
                st_idx++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          idx;
        int          cycles;
        int          total;
        bit          done;
        bit          timed_out;
        int          t;
        rst_n     <= 1'b0;
        mem_ack   <= 1'b0;
        mem_rdata <= 32'd0;
        st_idx    = 0;
        idx       = 0;
        done      = 1'b0;
        timed_out = 1'b0;
        void'($urandom(32'heb99_7d88));
        build_program();
        run_model();

        // Reset held for 3 cycles, outputs idle throughout
        repeat (2) begin
            @(negedge clk);
            check_true(T_RESET, !mem_req_valid && !retire_valid, "activity during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_true(T_RESET, !mem_req_valid && !retire_valid, "activity right after reset");

        while (!done && !timed_out) begin
            cycles = 0;
            while (!retire_valid && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!retire_valid) begin
                $display("Error: no instruction retired for %0d cycles", TIMEOUT);
                timed_out = 1'b1;
            end else if (retire.pc == `RV_RESET_PC + PROG_LEN * 4) begin
                done = 1'b1;
            end else if (idx >= exp_n) begin
                $display("Error: more instructions retired than the model executed");
                timed_out = 1'b1;
            end else begin
                check_value(T_BRANCH, exp_pc[idx], retire.pc);
                check_value(T_ORDER, 32'(exp_we[idx]), 32'(retire.rd_we));
                if (exp_we[idx]) begin
                    t = (exp_kind[idx] == 1) ? T_MEM : (exp_kind[idx] == 2) ? T_RAW : T_ORDER;
                    check_value(t, 32'(exp_rd[idx]), 32'(retire.rd));
                    check_value(t, exp_val[idx], retire.rd_value);
                end
                idx++;
                @(negedge clk);
            end
        end

        if (!timed_out) begin
            check_value(T_DONE, 32'(exp_n), 32'(idx));
            check_value(T_MEM, 32'(st_n), 32'(st_idx));
            // Debug busy drops during the self-loop redirect
            cycles = 0;
            while (dbg_busy && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            check_true(T_RESET, !dbg_busy, "dbg_busy never dropped in the self-loop");
        end

        total = 0;
        for (int i = 0; i < 6; i++) begin
            report_test(i);
            total += err_cnt[i];
        end
        $display("Totals: %0d tests, %0d errors, timeout %0d", 6, total, timed_out);
        if (total == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
